/* common/core_pkg.sv */
package core_pkg;

  localparam int XLEN = 32;
  localparam int ARCH_REGS = 32;

  typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
  typedef logic [XLEN-1:0] data_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_cmd_e;

  // Major opcodes
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 codes
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    arch_idx_t rs2;
    arch_idx_t rs1;
    logic [2:0] funct3;
    arch_idx_t rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    arch_idx_t rs1;
    logic [2:0] funct3;
    arch_idx_t rd;
    logic [6:0] opcode;
  } i_fields_t;

  // One fetched word, read by format once the opcode is known
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_word_u;

endpackage

/* common/rename_if.sv */
`timescale 1ns/1ps

interface rename_if #(
  parameter int PHYS_REGS = 64
) ();
  import core_pkg::*;

  localparam int PRD_W = $clog2(PHYS_REGS);

  logic req;
  arch_idx_t rs1;
  arch_idx_t rs2;
  arch_idx_t rd;
  logic needs_rd;

  logic [PRD_W-1:0] prs1;
  logic [PRD_W-1:0] prs2;
  logic [PRD_W-1:0] prd;
  logic [PRD_W-1:0] old_prd;
  // Readiness of the sources captured at the last request
  logic prs1_ready;
  logic prs2_ready;
  logic can_alloc;

  modport controller (
    output req, rs1, rs2, rd, needs_rd,
    input prs1, prs2, prd, old_prd, prs1_ready, prs2_ready, can_alloc
  );

  modport target (
    input req, rs1, rs2, rd, needs_rd,
    output prs1, prs2, prd, old_prd, prs1_ready, prs2_ready, can_alloc
  );

endinterface

/* common/wb_result_if.sv */
`timescale 1ns/1ps

interface wb_result_if #(
  parameter int PHYS_REGS = 64,
  parameter int ROB_DEPTH = 16
) ();
  import core_pkg::*;

  localparam int PRD_W = $clog2(PHYS_REGS);
  localparam int ROB_W = $clog2(ROB_DEPTH);

  // One-cycle pulse per executed instruction
  logic valid;
  logic [PRD_W-1:0] prd;
  logic [ROB_W-1:0] rob_idx;
  data_t result;

  modport source (
    output valid,
    output prd,
    output rob_idx,
    output result
  );

  modport sink (
    input valid,
    input prd,
    input rob_idx,
    input result
  );

endinterface

/* flist.f */
common/core_pkg.sv
common/wb_result_if.sv
common/rename_if.sv
rename/rename_unit.sv
rob/reorder_buffer.sv
logic/issue_control.sv
logic/exec_unit.sv
logic/ooo_core.sv
tb/commit_checker.sv
tb/tb_ooo_core.sv

/* logic/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
  parameter int PHYS_REGS = 64,
  parameter int ROB_DEPTH = 16
) (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input core_pkg::alu_cmd_e issue_cmd,
  input logic [$clog2(PHYS_REGS)-1:0] issue_prs1,
  input logic [$clog2(PHYS_REGS)-1:0] issue_prs2,
  input core_pkg::data_t issue_imm,
  input logic issue_use_imm,
  input logic [$clog2(PHYS_REGS)-1:0] issue_prd,
  input logic [$clog2(ROB_DEPTH)-1:0] issue_rob_idx,
  wb_result_if.source wb
);
  import core_pkg::*;

  data_t rf_q [PHYS_REGS];
  data_t op1;
  data_t op2;
  data_t alu_out;

  assign op1 = rf_q[issue_prs1];
  assign op2 = issue_use_imm ? issue_imm : rf_q[issue_prs2];

  always_comb begin
    case (issue_cmd)
      ALU_ADD: alu_out = op1 + op2;
      ALU_SUB: alu_out = op1 - op2;
      ALU_AND: alu_out = op1 & op2;
      ALU_OR: alu_out = op1 | op2;
      ALU_XOR: alu_out = op1 ^ op2;
      ALU_SLL: alu_out = op1 << op2[4:0];
      ALU_SRL: alu_out = op1 >> op2[4:0];
      ALU_SLT: alu_out = {{(XLEN - 1){1'b0}}, $signed(op1) < $signed(op2)};
      default: alu_out = '0;
    endcase
  end

  // Architectural state starts at zero, physical 0 stays zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        rf_q[i] <= '0;
      end
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= issue_valid;
      if (wb.valid && (wb.prd != '0)) begin
        rf_q[wb.prd] <= wb.result;
      end
    end
  end

  // Writes to x0 land on physical 0 and carry zero
  always_ff @(posedge clk) begin
    wb.prd <= issue_prd;
    wb.rob_idx <= issue_rob_idx;
    wb.result <= (issue_prd == '0) ? '0 : alu_out;
  end

endmodule

/* logic/issue_control.sv */
`timescale 1ns/1ps

module issue_control #(
  parameter int PHYS_REGS = 64,
  parameter int ROB_DEPTH = 16
) (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input core_pkg::data_t wb_dat_i,
  output logic wb_ack,
  output logic wb_err,
  rename_if.controller rename,
  input logic rob_full,
  input logic [$clog2(ROB_DEPTH)-1:0] rob_tail,
  output logic dispatch_valid,
  output logic issue_valid,
  output core_pkg::alu_cmd_e issue_cmd,
  output logic [$clog2(PHYS_REGS)-1:0] issue_prs1,
  output logic [$clog2(PHYS_REGS)-1:0] issue_prs2,
  output core_pkg::data_t issue_imm,
  output logic issue_use_imm,
  output logic [$clog2(PHYS_REGS)-1:0] issue_prd,
  output logic [$clog2(ROB_DEPTH)-1:0] issue_rob_idx
);
  import core_pkg::*;

  instr_word_u word;
  alu_cmd_e dec_cmd;
  logic dec_legal;
  logic dec_use_imm;
  data_t dec_imm;
  arch_idx_t dec_rs2;
  logic needs_rd;
  logic can_take;
  logic accept;
  logic reject;
  logic occupied_q;

  assign word = wb_dat_i;

  always_comb begin
    dec_cmd = ALU_ADD;
    dec_legal = 1'b0;
    dec_use_imm = 1'b0;
    dec_imm = {{20{word.i.imm12[11]}}, word.i.imm12};
    dec_rs2 = word.r.rs2;
    if (word.r.opcode == OPC_OP) begin
      dec_legal = 1'b1;
      case ({word.r.funct7, word.r.funct3})
        {F7_BASE, F3_ADD_SUB}: dec_cmd = ALU_ADD;
        {F7_ALT, F3_ADD_SUB}: dec_cmd = ALU_SUB;
        {F7_BASE, F3_SLL}: dec_cmd = ALU_SLL;
        {F7_BASE, F3_SLT}: dec_cmd = ALU_SLT;
        {F7_BASE, F3_XOR}: dec_cmd = ALU_XOR;
        {F7_BASE, F3_SRL}: dec_cmd = ALU_SRL;
        {F7_BASE, F3_OR}: dec_cmd = ALU_OR;
        {F7_BASE, F3_AND}: dec_cmd = ALU_AND;
        default: dec_legal = 1'b0;
      endcase
    end else if (word.i.opcode == OPC_OP_IMM) begin
      dec_legal = 1'b1;
      dec_use_imm = 1'b1;
      // No second source, so it reads x0 which is always ready
      dec_rs2 = '0;
      case (word.i.funct3)
        F3_ADD_SUB: dec_cmd = ALU_ADD;
        F3_SLT: dec_cmd = ALU_SLT;
        F3_XOR: dec_cmd = ALU_XOR;
        F3_OR: dec_cmd = ALU_OR;
        F3_AND: dec_cmd = ALU_AND;
        F3_SLL: begin
          dec_cmd = ALU_SLL;
          dec_legal = (word.i.imm12[11:5] == F7_BASE);
        end
        F3_SRL: begin
          dec_cmd = ALU_SRL;
          dec_legal = (word.i.imm12[11:5] == F7_BASE);
        end
        default: dec_legal = 1'b0;
      endcase
    end
  end

  assign needs_rd = dec_legal && (word.r.rd != '0);

  // Hold off while responding or while the issue slot is full
  assign can_take = wb_cyc && wb_stb && !wb_ack && !wb_err && !occupied_q;
  assign accept = can_take && dec_legal && (rename.can_alloc || !needs_rd) && !rob_full;
  assign reject = can_take && !dec_legal;

  assign rename.req = accept;
  assign rename.rs1 = word.r.rs1;
  assign rename.rs2 = dec_rs2;
  assign rename.rd = word.r.rd;
  assign rename.needs_rd = needs_rd;

  assign dispatch_valid = accept;
  assign issue_valid = occupied_q && rename.prs1_ready && rename.prs2_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      occupied_q <= 1'b0;
    end else begin
      wb_ack <= accept;
      wb_err <= reject;
      if (accept) begin
        occupied_q <= 1'b1;
      end else if (issue_valid) begin
        occupied_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_cmd <= dec_cmd;
      issue_prs1 <= rename.prs1;
      issue_prs2 <= rename.prs2;
      issue_imm <= dec_imm;
      issue_use_imm <= dec_use_imm;
      issue_prd <= rename.prd;
      issue_rob_idx <= rob_tail;
    end
  end

endmodule

/* logic/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core #(
  parameter int PHYS_REGS = 64,
  parameter int ROB_DEPTH = 16
) (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input core_pkg::data_t wb_dat_i,
  output logic wb_ack,
  output logic wb_err,
  output logic commit_valid,
  output core_pkg::arch_idx_t commit_rd,
  output core_pkg::data_t commit_data
);
  import core_pkg::*;

  localparam int PRD_W = $clog2(PHYS_REGS);
  localparam int ROB_W = $clog2(ROB_DEPTH);

  logic rob_full;
  logic [ROB_W-1:0] rob_tail;
  logic dispatch_valid;
  logic issue_valid;
  alu_cmd_e issue_cmd;
  logic [PRD_W-1:0] issue_prs1;
  logic [PRD_W-1:0] issue_prs2;
  data_t issue_imm;
  logic issue_use_imm;
  logic [PRD_W-1:0] issue_prd;
  logic [ROB_W-1:0] issue_rob_idx;
  logic [PRD_W-1:0] commit_old_prd;

  rename_if #(.PHYS_REGS(PHYS_REGS)) rename_bus ();
  wb_result_if #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) wb_bus ();

  issue_control #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) u_issue (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_dat_i, .wb_ack, .wb_err,
    .rename(rename_bus.controller), .rob_full, .rob_tail, .dispatch_valid,
    .issue_valid, .issue_cmd, .issue_prs1, .issue_prs2, .issue_imm,
    .issue_use_imm, .issue_prd, .issue_rob_idx
  );

  rename_unit #(.PHYS_REGS(PHYS_REGS)) u_rename (
    .clk, .rst, .rename(rename_bus.target), .wb(wb_bus.sink),
    .commit_valid, .commit_old_prd
  );

  reorder_buffer #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clk, .rst, .dispatch_valid, .dispatch_rd(rename_bus.rd),
    .dispatch_old_prd(rename_bus.old_prd), .wb(wb_bus.sink), .rob_full, .rob_tail,
    .commit_valid, .commit_rd, .commit_data, .commit_old_prd
  );

  exec_unit #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) u_exec (
    .clk, .rst, .issue_valid, .issue_cmd, .issue_prs1, .issue_prs2, .issue_imm,
    .issue_use_imm, .issue_prd, .issue_rob_idx, .wb(wb_bus.source)
  );

endmodule

/* rename/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit #(
  parameter int PHYS_REGS = 64
) (
  input logic clk,
  input logic rst,
  rename_if.target rename,
  wb_result_if.sink wb,
  input logic commit_valid,
  input logic [$clog2(PHYS_REGS)-1:0] commit_old_prd
);
  import core_pkg::*;

  localparam int PRD_W = $clog2(PHYS_REGS);

  logic [PRD_W-1:0] map_q [ARCH_REGS];
  logic [PRD_W-1:0] free_q [PHYS_REGS];
  // Depth is a power of two so the pointers wrap on their own
  logic [PRD_W-1:0] fl_head_q;
  logic [PRD_W-1:0] fl_tail_q;
  logic [PRD_W:0] fl_count_q;
  logic [PHYS_REGS-1:0] ready_q;
  logic [PRD_W-1:0] src1_q;
  logic [PRD_W-1:0] src2_q;
  logic alloc;
  logic release_reg;

  assign alloc = rename.req && rename.needs_rd && rename.can_alloc;
  // Physical 0 backs x0 and never returns to the pool
  assign release_reg = commit_valid && (commit_old_prd != '0);

  assign rename.can_alloc = (fl_count_q != '0);
  assign rename.prs1 = map_q[rename.rs1];
  assign rename.prs2 = map_q[rename.rs2];
  assign rename.prd = rename.needs_rd ? free_q[fl_head_q] : '0;
  assign rename.old_prd = map_q[rename.rd];

  // Re-read every cycle for the instruction held in the issue register
  assign rename.prs1_ready = ready_q[src1_q];
  assign rename.prs2_ready = ready_q[src2_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= PRD_W'(i);
      end
      // Only registers above the architectural set start out free
      for (int i = 0; i < PHYS_REGS; i++) begin
        free_q[i] <= PRD_W'(ARCH_REGS + i);
      end
      fl_head_q <= '0;
      fl_tail_q <= PRD_W'(PHYS_REGS - ARCH_REGS);
      fl_count_q <= (PRD_W + 1)'(PHYS_REGS - ARCH_REGS);
    end else begin
      if (alloc) begin
        map_q[rename.rd] <= free_q[fl_head_q];
        fl_head_q <= fl_head_q + 1'b1;
      end
      if (release_reg) begin
        free_q[fl_tail_q] <= commit_old_prd;
        fl_tail_q <= fl_tail_q + 1'b1;
      end
      fl_count_q <= fl_count_q + (PRD_W + 1)'(release_reg) - (PRD_W + 1)'(alloc);
    end
  end

  // Scoreboard and captured sources
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= '1;
      src1_q <= '0;
      src2_q <= '0;
    end else begin
      if (wb.valid) begin
        ready_q[wb.prd] <= 1'b1;
      end
      if (alloc) begin
        ready_q[free_q[fl_head_q]] <= 1'b0;
      end
      if (rename.req) begin
        src1_q <= rename.prs1;
        src2_q <= rename.prs2;
      end
    end
  end

endmodule

/* rob/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer #(
  parameter int PHYS_REGS = 64,
  parameter int ROB_DEPTH = 16
) (
  input logic clk,
  input logic rst,
  input logic dispatch_valid,
  input core_pkg::arch_idx_t dispatch_rd,
  input logic [$clog2(PHYS_REGS)-1:0] dispatch_old_prd,
  wb_result_if.sink wb,
  output logic rob_full,
  output logic [$clog2(ROB_DEPTH)-1:0] rob_tail,
  output logic commit_valid,
  output core_pkg::arch_idx_t commit_rd,
  output core_pkg::data_t commit_data,
  output logic [$clog2(PHYS_REGS)-1:0] commit_old_prd
);
  import core_pkg::*;

  localparam int PRD_W = $clog2(PHYS_REGS);
  localparam int ROB_W = $clog2(ROB_DEPTH);

  arch_idx_t rd_q [ROB_DEPTH];
  logic [PRD_W-1:0] old_prd_q [ROB_DEPTH];
  data_t result_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;
  logic [ROB_W-1:0] head_q;
  logic [ROB_W-1:0] tail_q;
  logic [ROB_W:0] count_q;

  assign rob_full = (count_q == (ROB_W + 1)'(ROB_DEPTH));
  assign rob_tail = tail_q;

  // Head retires once its result is in
  assign commit_valid = (count_q != '0) && done_q[head_q];
  assign commit_rd = rd_q[head_q];
  assign commit_data = result_q[head_q];
  assign commit_old_prd = old_prd_q[head_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= '0;
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else begin
      if (dispatch_valid) begin
        done_q[tail_q] <= 1'b0;
        tail_q <= tail_q + 1'b1;
      end
      if (wb.valid) begin
        done_q[wb.rob_idx] <= 1'b1;
      end
      if (commit_valid) begin
        done_q[head_q] <= 1'b0;
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + (ROB_W + 1)'(dispatch_valid) - (ROB_W + 1)'(commit_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch_valid) begin
      rd_q[tail_q] <= dispatch_rd;
      old_prd_q[tail_q] <= dispatch_old_prd;
    end
    if (wb.valid) begin
      result_q[wb.rob_idx] <= wb.result;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_ooo_core \
  --Mdir obj_dir -o sim_tb_ooo_core
./obj_dir/sim_tb_ooo_core | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  echo "run.sh: PASS"
  exit 0
else
  echo "run.sh: FAIL"
  exit 1
fi

/* tb/commit_checker.sv */
`timescale 1ns/1ps

module commit_checker (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic [31:0] wb_dat_i,
  input logic wb_ack,
  input logic wb_err,
  input logic exp_err,
  input logic commit_valid,
  input logic [4:0] commit_rd,
  input logic [31:0] commit_data,
  output int errors,
  output int checks,
  output int pending
);

  // Architectural state in acknowledge order
  logic [31:0] arch_q [32];
  // Expected commits as {rd, value}, oldest first
  logic [36:0] expect_q [$];
  logic [36:0] exp_entry;
  logic [31:0] value;
  int err_cnt = 0;
  int check_cnt = 0;

  function automatic logic [31:0] reference_result(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    a = arch_q[w[19:15]];
    // OP-IMM takes the sign-extended immediate as second operand
    b = (w[6:0] == 7'h13) ? {{20{w[31]}}, w[31:20]} : arch_q[w[24:20]];
    case (w[14:12])
      3'b000: res = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: res = a >> b[4:0];
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return (w[11:7] == 5'd0) ? 32'd0 : res;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 32; r++) begin
        arch_q[r] = '0;
      end
      expect_q.delete();
    end else begin
      if (wb_ack || wb_err) begin
        if (!(wb_cyc && wb_stb)) begin
          $display("Unexpected bus response at %0t while no request was open", $time);
          err_cnt++;
        end else begin
          check_cnt++;
          if (wb_ack == wb_err || wb_err != exp_err) begin
            $display("** Error at %0t: word %h got ack=%0b err=%0b, expected %s",
                     $time, wb_dat_i, wb_ack, wb_err, exp_err ? "err" : "ack");
            err_cnt++;
          end
          if (wb_ack && !wb_err) begin
            value = reference_result(wb_dat_i);
            expect_q.push_back({wb_dat_i[11:7], value});
            if (wb_dat_i[11:7] != 5'd0) begin
              arch_q[wb_dat_i[11:7]] = value;
            end
          end
        end
      end
      if (commit_valid) begin
        if (expect_q.size() == 0) begin
          $display("Unexpected commit of x%0d at %0t with nothing outstanding",
                   commit_rd, $time);
          err_cnt++;
        end else begin
          exp_entry = expect_q.pop_front();
          check_cnt++;
          if ({commit_rd, commit_data} != exp_entry) begin
            $display("** Error at %0t: commit x%0d = %h, expected x%0d = %h", $time,
                     commit_rd, commit_data, exp_entry[36:32], exp_entry[31:0]);
            err_cnt++;
          end
        end
      end
    end
    errors <= err_cnt;
    checks <= check_cnt;
    pending <= expect_q.size();
  end

endmodule

/* tb/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;

  logic clk;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic [31:0] wb_dat_i;
  logic wb_ack;
  logic wb_err;
  logic commit_valid;
  logic [4:0] commit_rd;
  logic [31:0] commit_data;
  logic exp_err;
  int errors;
  int checks;
  int pending;

  // Stimulus table
  logic [31:0] tbl_word [$];
  logic tbl_err [$];
  int tbl_gap [$];
  int tbl_test [$];
  string test_name [5];
  logic table_built = 1'b0;
  int seed = 32'h0173_5a41;
  int cycles;
  int limit;

  ooo_core #(.PHYS_REGS(64), .ROB_DEPTH(16)) u_dut (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_dat_i, .wb_ack, .wb_err,
    .commit_valid, .commit_rd, .commit_data
  );

  commit_checker u_checker (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_dat_i, .wb_ack, .wb_err, .exp_err,
    .commit_valid, .commit_rd, .commit_data, .errors, .checks, .pending
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic err, input int test_id,
                           input logic tight);
    int gap;
    gap = tight ? 0 : ($random(seed) & 3);
    tbl_word.push_back(word);
    tbl_err.push_back(err);
    tbl_gap.push_back(gap);
    tbl_test.push_back(test_id);
  endtask

  // Hold the request until the slave answers, then idle at least one cycle
  task automatic send_word(input logic [31:0] word, input logic err, input int gap);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_dat_i <= word;
    exp_err <= err;
    @(posedge clk);
    while (!(wb_ack || wb_err)) begin
      @(posedge clk);
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    repeat (gap + 1) @(posedge clk);
  endtask

  task automatic build_table();
    logic [4:0] prev_rd;
    logic [4:0] rd;
    // Dependent chain
    add_entry(i_word(12'd5, 5'd0, 3'b000, 5'd1), 1'b0, 1, 1'b0);
    add_entry(i_word(12'd7, 5'd1, 3'b000, 5'd2), 1'b0, 1, 1'b0);
    add_entry(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, 1, 1'b0);
    add_entry(r_word(7'h00, 5'd3, 5'd3, 3'b000, 5'd3), 1'b0, 1, 1'b0);
    add_entry(i_word(12'hfff, 5'd3, 3'b000, 5'd4), 1'b0, 1, 1'b0);
    add_entry(r_word(7'h00, 5'd1, 5'd4, 3'b000, 5'd5), 1'b0, 1, 1'b0);
    // Every ALU command, then writes to x0
    add_entry(i_word(12'hfec, 5'd0, 3'b000, 5'd6), 1'b0, 2, 1'b0);
    add_entry(i_word(12'd3, 5'd0, 3'b000, 5'd7), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h20, 5'd6, 5'd1, 3'b000, 5'd8), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd2, 5'd6, 3'b111, 5'd9), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd7, 5'd6, 3'b110, 5'd10), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd2, 5'd6, 3'b100, 5'd11), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd7, 5'd7, 3'b001, 5'd12), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd7, 5'd6, 3'b101, 5'd13), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd7, 5'd6, 3'b010, 5'd14), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd6, 5'd7, 3'b010, 5'd15), 1'b0, 2, 1'b0);
    add_entry(i_word(12'h0f0, 5'd6, 3'b111, 5'd16), 1'b0, 2, 1'b0);
    add_entry(i_word(12'hf00, 5'd7, 3'b110, 5'd17), 1'b0, 2, 1'b0);
    add_entry(i_word(12'h555, 5'd6, 3'b100, 5'd18), 1'b0, 2, 1'b0);
    add_entry(i_word(12'd29, 5'd7, 3'b001, 5'd19), 1'b0, 2, 1'b0);
    add_entry(i_word(12'd4, 5'd6, 3'b101, 5'd20), 1'b0, 2, 1'b0);
    add_entry(i_word(12'hfed, 5'd6, 3'b010, 5'd21), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b0, 2, 1'b0);
    add_entry(i_word(12'd9, 5'd0, 3'b000, 5'd0), 1'b0, 2, 1'b0);
    add_entry(r_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd22), 1'b0, 2, 1'b0);
    // System, load, MUL, SRAI and SRA are all rejected
    add_entry(32'h0000_0073, 1'b1, 3, 1'b0);
    add_entry(i_word(12'd1, 5'd22, 3'b000, 5'd23), 1'b0, 3, 1'b0);
    add_entry(32'h0040_a103, 1'b1, 3, 1'b0);
    add_entry(r_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd25), 1'b1, 3, 1'b0);
    add_entry(r_word(7'h00, 5'd5, 5'd23, 3'b000, 5'd24), 1'b0, 3, 1'b0);
    add_entry(i_word(12'h401, 5'd6, 3'b101, 5'd26), 1'b1, 3, 1'b0);
    add_entry(r_word(7'h20, 5'd7, 5'd6, 3'b101, 5'd27), 1'b1, 3, 1'b0);
    // Back-to-back dependent writes through x25..x31
    prev_rd = 5'd24;
    for (int i = 0; i < 36; i++) begin
      rd = 5'(25 + i % 7);
      if (i % 2 == 0) begin
        add_entry(i_word(12'(i + 1), prev_rd, 3'b000, rd), 1'b0, 4, 1'b1);
      end else begin
        add_entry(r_word(7'h00, 5'd1, prev_rd, 3'b000, rd), 1'b0, 4, 1'b1);
      end
      prev_rd = rd;
    end
  endtask

  initial begin
    cycles = 0;
    wait (table_built);
    limit = tbl_word.size() * 40 + 200;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int test_errors;
    int prev_errors;
    int failed_tests;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_dat_i = '0;
    exp_err = 1'b0;
    prev_errors = 0;
    failed_tests = 0;
    test_name = '{"quiet after reset", "dependent chain", "ALU commands and x0",
                  "illegal opcodes", "free list under load"};
    build_table();
    table_built = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < 5; t++) begin
      // Test 0 only idles, the checker flags any stray response
      if (t == 0) begin
        repeat (12) @(posedge clk);
      end
      for (int i = 0; i < tbl_word.size(); i++) begin
        if (tbl_test[i] == t) begin
          send_word(tbl_word[i], tbl_err[i], tbl_gap[i]);
        end
      end
      while (pending != 0) begin
        @(posedge clk);
      end
      @(posedge clk);
      test_errors = errors - prev_errors;
      prev_errors = errors;
      if (test_errors != 0) begin
        failed_tests++;
      end
      $display("test %0d %s: %s, %0d errors", t, test_name[t],
               (test_errors == 0) ? "ok" : "FAILED", test_errors);
    end
    $display("tests 5, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
